/* list.f */
src/soc_mem_pkg.sv
src/fetch_enable_delay.sv
src/region_decoder.sv
src/tcm_ram.sv
src/response_merge.sv
src/tcm_soc_fabric.sv
verif/tb_tcm_soc_fabric.sv

/* run.sh */
#!/bin/sh
# build and run the fabric testbench with Verilator from the project root

cd "$(dirname "$0")" &&
verilator --binary --assert -f list.f --top-module tb_tcm_soc_fabric \
	-o tb_tcm_soc_fabric &&
./obj_dir/tb_tcm_soc_fabric ||
{
	echo "run.sh: build or simulation did not succeed"
	exit 1
}

/* src/fetch_enable_delay.sv */
module fetch_enable_delay
(
	input  logic clk_i,
	input  logic resetn,
	output logic fetch_enable_o
);

	// ones shift in from bit 0 once out of reset
	logic [soc_mem_pkg::FETCH_DELAY-2:0] fill_q;

	always_ff @(posedge clk_i)
	begin
		if (!resetn)
		begin
			fill_q <= '0;
			fetch_enable_o <= 1'b0;
		end
		else
		begin
			fill_q <= {fill_q[soc_mem_pkg::FETCH_DELAY-3:0], 1'b1};
			// output register after the last stage
			fetch_enable_o <= fill_q[soc_mem_pkg::FETCH_DELAY-2];
		end
	end

endmodule

/* src/region_decoder.sv */
module region_decoder
(
	input  soc_mem_pkg::mem_req_t req_i,
	output soc_mem_pkg::mem_req_t tcm_req_o,
	output soc_mem_pkg::mem_req_t ext_req_o
);

	logic [soc_mem_pkg::REGION_HI-soc_mem_pkg::REGION_LO:0] region;
	logic hit_tcm;

	assign region = req_i.addr[soc_mem_pkg::REGION_HI:soc_mem_pkg::REGION_LO];
	assign hit_tcm = (region == soc_mem_pkg::TCM_REGION);

	always_comb
	begin
		// address, data and byte enables go to both sides
		tcm_req_o = req_i;
		ext_req_o = req_i;

		// only the strobe and write flag are steered
		if (hit_tcm)
		begin
			ext_req_o.req = 1'b0;
			ext_req_o.we = 1'b0;
		end
		else
		begin
			tcm_req_o.req = 1'b0;
			tcm_req_o.we = 1'b0;
		end
	end

	// a request never reaches both targets
	always_comb
	begin
		assert final (!(tcm_req_o.req && ext_req_o.req))
		else
			$error("region_decoder: request steered to both targets");
	end

	// a tcm write carries the core's write flag with it
	always_comb
	begin
		assert final (!(tcm_req_o.we && !tcm_req_o.req))
		else
			$error("region_decoder: tcm write flag without strobe");
	end

endmodule

/* src/response_merge.sv */
module response_merge
(
	input  soc_mem_pkg::mem_rsp_t tcm_rsp_i,
	input  soc_mem_pkg::mem_rsp_t ext_rsp_i,
	output soc_mem_pkg::mem_rsp_t rsp_o
);

	logic tcm_sel;
	logic ext_sel;

	// tcm wins a same-cycle collision
	assign tcm_sel = tcm_rsp_i.rvalid;
	assign ext_sel = ext_rsp_i.rvalid && !tcm_rsp_i.rvalid;

	always_comb
	begin
		// only one target holds a request at a time
		rsp_o.gnt = tcm_rsp_i.gnt | ext_rsp_i.gnt;
		rsp_o.rvalid = tcm_rsp_i.rvalid | ext_rsp_i.rvalid;

		if (tcm_sel)
			rsp_o.rdata = tcm_rsp_i.rdata;
		else if (ext_sel)
			rsp_o.rdata = ext_rsp_i.rdata;
		else
			rsp_o.rdata = '0;
	end

	// tcm and external slave never answer in the same cycle
	always_comb
	begin
		assert final (!(tcm_rsp_i.rvalid && ext_rsp_i.rvalid))
		else
			$error("response_merge: tcm and external read-valid together");
	end

	// both targets never grant the same request
	always_comb
	begin
		assert final (!(tcm_rsp_i.gnt && ext_rsp_i.gnt))
		else
			$error("response_merge: tcm and external grant together");
	end

endmodule

/* src/soc_mem_pkg.sv */
package soc_mem_pkg;

	// bus widths
	localparam int ADDR_W = 34;
	localparam int DATA_W = 32;
	localparam int BE_W = DATA_W / 8;

	// region field at the top of the address
	localparam int REGION_HI = 33;
	localparam int REGION_LO = 28;
	localparam logic [REGION_HI-REGION_LO:0] TCM_REGION = 6'd8;

	// tcm geometry, word addressed
	localparam int TCM_WORDS = 1024;
	localparam int TCM_AW = $clog2(TCM_WORDS);

	// cycles from reset release to fetch enable
	localparam int FETCH_DELAY = 5;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [BE_W-1:0] be_t;
	typedef logic [TCM_AW-1:0] tcm_idx_t;

	// core side request, plain strobes
	typedef struct packed
	{
		// request strobe
		logic req;
		// write flag, ignored on instruction fetch
		logic we;
		be_t be;
		addr_t addr;
		data_t wdata;
	} mem_req_t;

	// response back to the core
	typedef struct packed
	{
		// same-cycle grant
		logic gnt;
		// one pulse per accepted request, writes included
		logic rvalid;
		data_t rdata;
	} mem_rsp_t;

endpackage

/* src/tcm_ram.sv */
module tcm_ram
(
	input  logic clk_i,
	input  logic resetn,

	// instruction port, read only
	input  soc_mem_pkg::mem_req_t instr_req_i,
	output soc_mem_pkg::mem_rsp_t instr_rsp_o,

	// data port with byte enables
	input  soc_mem_pkg::mem_req_t data_req_i,
	output soc_mem_pkg::mem_rsp_t data_rsp_o
);

	soc_mem_pkg::data_t mem [soc_mem_pkg::TCM_WORDS];

	soc_mem_pkg::tcm_idx_t instr_idx;
	soc_mem_pkg::tcm_idx_t data_idx;

	logic instr_rvalid_q;
	logic data_rvalid_q;
	soc_mem_pkg::data_t instr_rdata_q;
	soc_mem_pkg::data_t data_rdata_q;

	// word index, byte offset dropped
	assign instr_idx = instr_req_i.addr[soc_mem_pkg::TCM_AW+1:2];
	assign data_idx = data_req_i.addr[soc_mem_pkg::TCM_AW+1:2];

	// only enabled bytes are written
	always_ff @(posedge clk_i)
	begin
		if (data_req_i.req && data_req_i.we)
		begin
			for (int b = 0; b < soc_mem_pkg::BE_W; b++)
			begin
				if (data_req_i.be[b])
					mem[data_idx][8*b +: 8] <= data_req_i.wdata[8*b +: 8];
			end
		end
	end

	// read ports, a write in the same cycle leaves the old word here
	always_ff @(posedge clk_i)
	begin
		if (instr_req_i.req)
			instr_rdata_q <= mem[instr_idx];
		if (data_req_i.req)
			data_rdata_q <= mem[data_idx];
	end

	always_ff @(posedge clk_i)
	begin
		if (!resetn)
		begin
			instr_rvalid_q <= 1'b0;
			data_rvalid_q <= 1'b0;
		end
		else
		begin
			instr_rvalid_q <= instr_req_i.req;
			data_rvalid_q <= data_req_i.req;
		end
	end

	// grant in the request cycle, response one cycle later
	always_comb
	begin
		instr_rsp_o.gnt = instr_req_i.req;
		instr_rsp_o.rvalid = instr_rvalid_q;
		instr_rsp_o.rdata = instr_rdata_q;
		data_rsp_o.gnt = data_req_i.req;
		data_rsp_o.rvalid = data_rvalid_q;
		data_rsp_o.rdata = data_rdata_q;
	end

	// every read-valid answers a request from the cycle before
	assert property (@(posedge clk_i) disable iff (!resetn)
		instr_rsp_o.rvalid |-> $past(instr_req_i.req))
	else
		$error("tcm_ram: instruction read-valid without request");

	assert property (@(posedge clk_i) disable iff (!resetn)
		data_rsp_o.rvalid |-> $past(data_req_i.req))
	else
		$error("tcm_ram: data read-valid without request");

endmodule

/* src/tcm_soc_fabric.sv */
module tcm_soc_fabric
(
	input  logic clk_i,
	input  logic resetn,

	// core control
	output logic fetch_enable_o,

	// core instruction port
	input  soc_mem_pkg::mem_req_t instr_req_i,
	output soc_mem_pkg::mem_rsp_t instr_rsp_o,

	// core data port
	input  soc_mem_pkg::mem_req_t data_req_i,
	output soc_mem_pkg::mem_rsp_t data_rsp_o,

	// external instruction slave
	output soc_mem_pkg::mem_req_t ext_instr_req_o,
	input  soc_mem_pkg::mem_rsp_t ext_instr_rsp_i,

	// external data slave
	output soc_mem_pkg::mem_req_t ext_data_req_o,
	input  soc_mem_pkg::mem_rsp_t ext_data_rsp_i
);

	// decoded requests toward the tcm
	soc_mem_pkg::mem_req_t instr_tcm_req;
	soc_mem_pkg::mem_req_t data_tcm_req;

	// tcm responses before the merge
	soc_mem_pkg::mem_rsp_t instr_tcm_rsp;
	soc_mem_pkg::mem_rsp_t data_tcm_rsp;

	// holds fetch off after reset
	fetch_enable_delay u_fetch_enable_delay
	(
		.clk_i			(clk_i			),
		.resetn			(resetn			),
		.fetch_enable_o	(fetch_enable_o	)
	);

	// decode stage
	region_decoder u_instr_decoder
	(
		.req_i			(instr_req_i		),
		.tcm_req_o		(instr_tcm_req		),
		.ext_req_o		(ext_instr_req_o	)
	);

	region_decoder u_data_decoder
	(
		.req_i			(data_req_i			),
		.tcm_req_o		(data_tcm_req		),
		.ext_req_o		(ext_data_req_o		)
	);

	// target stage, shared by both ports
	tcm_ram u_tcm_ram
	(
		.clk_i			(clk_i				),
		.resetn			(resetn				),
		.instr_req_i	(instr_tcm_req		),
		.instr_rsp_o	(instr_tcm_rsp		),
		.data_req_i		(data_tcm_req		),
		.data_rsp_o		(data_tcm_rsp		)
	);

	// merge stage
	response_merge u_instr_merge
	(
		.tcm_rsp_i		(instr_tcm_rsp		),
		.ext_rsp_i		(ext_instr_rsp_i	),
		.rsp_o			(instr_rsp_o		)
	);

	response_merge u_data_merge
	(
		.tcm_rsp_i		(data_tcm_rsp		),
		.ext_rsp_i		(ext_data_rsp_i		),
		.rsp_o			(data_rsp_o			)
	);

endmodule

/* verif/fabric_stim.txt */
# kind: 0 instruction, 1 data, 2 instruction issued together with the next data line
# kind we addr wdata be expected_rdata, all hex, expected ffffffff marks an unchecked write
1 1 080000000 11223344 f ffffffff
1 1 080000000 aabbccdd 3 ffffffff
1 1 080000004 deadbeef f ffffffff
1 1 080000004 00550000 4 ffffffff
1 1 080000008 01020304 f ffffffff
1 1 080000008 f0e0d0c0 9 ffffffff
1 1 080000ffc 0badf00d f ffffffff
1 0 080000000 00000000 0 1122ccdd
1 0 080000004 00000000 0 de55beef
1 0 080000008 00000000 0 f00203c0
0 0 080000ffc 00000000 0 0badf00d
0 0 080000004 00000000 0 de55beef
1 1 000001000 cafef00d 5 ffffffff
1 1 070000004 12345678 f ffffffff
1 0 000002004 00000000 0 a5a585a1
1 0 3f0000000 00000000 0 55a5a5a5
0 0 100000008 00000000 0 a5a5a5ad
0 0 090000004 00000000 0 35a5a5a1
1 0 080000000 00000000 0 1122ccdd
0 0 080000004 00000000 0 de55beef
2 0 080000008 00000000 0 f00203c0
1 0 080000ffc 00000000 0 0badf00d
2 0 080000000 00000000 0 1122ccdd
1 0 080000000 00000000 0 1122ccdd
2 0 080000004 00000000 0 de55beef
1 1 080000004 77000000 8 ffffffff
1 0 080000004 00000000 0 7755beef
0 0 080000004 00000000 0 7755beef

/* verif/tb_tcm_soc_fabric.sv */
module tb_tcm_soc_fabric;

	timeunit 1ns;
	timeprecision 1ps;

	logic clk_i = 1'b0;
	logic resetn;
	logic fetch_enable_o;

	soc_mem_pkg::mem_req_t instr_req;
	soc_mem_pkg::mem_rsp_t instr_rsp;
	soc_mem_pkg::mem_req_t data_req;
	soc_mem_pkg::mem_rsp_t data_rsp;
	soc_mem_pkg::mem_req_t ext_instr_req;
	soc_mem_pkg::mem_rsp_t ext_instr_rsp;
	soc_mem_pkg::mem_req_t ext_data_req;
	soc_mem_pkg::mem_rsp_t ext_data_rsp;

	always #20 clk_i = ~clk_i;

	tcm_soc_fabric u_tcm_soc_fabric
	(
		.clk_i				(clk_i			),
		.resetn				(resetn			),
		.fetch_enable_o		(fetch_enable_o	),
		.instr_req_i		(instr_req		),
		.instr_rsp_o		(instr_rsp		),
		.data_req_i			(data_req		),
		.data_rsp_o			(data_rsp		),
		.ext_instr_req_o	(ext_instr_req	),
		.ext_instr_rsp_i	(ext_instr_rsp	),
		.ext_data_req_o		(ext_data_req	),
		.ext_data_rsp_i		(ext_data_rsp	)
	);

	ext_slave_model u_ext_instr_slave
	(
		.clk_i	(clk_i			),
		.resetn	(resetn			),
		.req_i	(ext_instr_req	),
		.rsp_o	(ext_instr_rsp	)
	);

	ext_slave_model u_ext_data_slave
	(
		.clk_i	(clk_i			),
		.resetn	(resetn			),
		.req_i	(ext_data_req	),
		.rsp_o	(ext_data_rsp	)
	);

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	function automatic logic in_tcm(input soc_mem_pkg::addr_t addr);
		return (addr[soc_mem_pkg::REGION_HI:soc_mem_pkg::REGION_LO] == soc_mem_pkg::TCM_REGION);
	endfunction

	// 0 instr grant, 1 data grant, 2 instr read-valid, 3 data read-valid
	function automatic logic flag_now(input int sel);
		case (sel)
			0: return instr_rsp.gnt;
			1: return data_rsp.gnt;
			2: return instr_rsp.rvalid;
			default: return data_rsp.rvalid;
		endcase
	endfunction

	task automatic wait_flag(input int sel, input string what, output int cycles);
		cycles = 0;
		do
		begin
			@(negedge clk_i);
			cycles++;
		end
		while (!flag_now(sel) && cycles < 20);
		if (!flag_now(sel))
			stop_with_failure($sformatf("no %s within 20 cycles", what));
	endtask

	task automatic check_ext_req(input string port, input soc_mem_pkg::mem_req_t got,
		input soc_mem_pkg::mem_req_t sent);
		check_value($sformatf("ext_%s_req_o.req", port), 64'(got.req), 64'd1);
		check_value($sformatf("ext_%s_req_o.we", port), 64'(got.we), 64'(sent.we));
		check_value($sformatf("ext_%s_req_o.be", port), 64'(got.be), 64'(sent.be));
		check_value($sformatf("ext_%s_req_o.addr", port), 64'(got.addr), 64'(sent.addr));
		check_value($sformatf("ext_%s_req_o.wdata", port), 64'(got.wdata), 64'(sent.wdata));
	endtask

	task automatic run_access(input logic is_data, input logic we,
		input soc_mem_pkg::addr_t addr, input soc_mem_pkg::data_t wdata,
		input soc_mem_pkg::be_t be, input soc_mem_pkg::data_t exp);
		soc_mem_pkg::mem_req_t r;
		soc_mem_pkg::mem_req_t ext;
		soc_mem_pkg::data_t rdata;
		string port;
		int cycles;
		r.req = 1'b1;
		r.we = we;
		r.be = be;
		r.addr = addr;
		r.wdata = wdata;
		port = is_data ? "data" : "instr";
		@(posedge clk_i);
		if (is_data)
			data_req <= r;
		else
			instr_req <= r;
		wait_flag(is_data ? 1 : 0, {port, " grant"}, cycles);
		ext = is_data ? ext_data_req : ext_instr_req;
		if (in_tcm(addr))
			check_value($sformatf("ext_%s_req_o.req", port), 64'(ext.req), 64'd0);
		else
			check_ext_req(port, ext, r);
		@(posedge clk_i);
		if (is_data)
			data_req <= '0;
		else
			instr_req <= '0;
		wait_flag(is_data ? 3 : 2, {port, " read-valid"}, cycles);
		// tcm answers exactly one cycle after the grant
		if (in_tcm(addr))
			check_value({port, " tcm latency"}, 64'(cycles), 64'd1);
		rdata = is_data ? data_rsp.rdata : instr_rsp.rdata;
		if (exp != '1)
			check_value({port, "_rsp_o.rdata"}, 64'(rdata), 64'(exp));
	endtask

	// instruction read and data access to the tcm in one cycle
	task automatic run_pair(input soc_mem_pkg::addr_t i_addr, input soc_mem_pkg::data_t i_exp,
		input logic d_we, input soc_mem_pkg::addr_t d_addr, input soc_mem_pkg::data_t d_wdata,
		input soc_mem_pkg::be_t d_be, input soc_mem_pkg::data_t d_exp);
		soc_mem_pkg::mem_req_t ri;
		soc_mem_pkg::mem_req_t rd;
		int cycles;
		ri = '0;
		ri.req = 1'b1;
		ri.addr = i_addr;
		rd.req = 1'b1;
		rd.we = d_we;
		rd.be = d_be;
		rd.addr = d_addr;
		rd.wdata = d_wdata;
		if (!in_tcm(i_addr) || !in_tcm(d_addr))
			stop_with_failure("paired stimulus lines must both address the TCM");
		@(posedge clk_i);
		instr_req <= ri;
		data_req <= rd;
		wait_flag(0, "instr grant", cycles);
		check_value("data_rsp_o.gnt", 64'(data_rsp.gnt), 64'd1);
		@(posedge clk_i);
		instr_req <= '0;
		data_req <= '0;
		wait_flag(2, "instr read-valid", cycles);
		check_value("instr tcm latency", 64'(cycles), 64'd1);
		check_value("data_rsp_o.rvalid", 64'(data_rsp.rvalid), 64'd1);
		check_value("instr_rsp_o.rdata", 64'(instr_rsp.rdata), 64'(i_exp));
		if (d_exp != '1)
			check_value("data_rsp_o.rdata", 64'(data_rsp.rdata), 64'(d_exp));
	endtask

	initial
	begin
		string line;
		int fd;
		int code;
		int count;
		int lines_run;
		logic [3:0] kind;
		logic [3:0] we;
		soc_mem_pkg::addr_t addr;
		soc_mem_pkg::data_t wdata;
		soc_mem_pkg::be_t be;
		soc_mem_pkg::data_t exp;
		logic pend_valid;
		soc_mem_pkg::addr_t pend_addr;
		soc_mem_pkg::data_t pend_exp;

		resetn = 1'b0;
		instr_req = '0;
		data_req = '0;
		lines_run = 0;
		pend_valid = 1'b0;

		fd = $fopen("verif/fabric_stim.txt", "r");
		if (fd == 0)
			stop_with_failure("cannot open the stimulus file verif/fabric_stim.txt");

		// fetch stays off through reset
		for (int i = 0; i < 8; i++)
		begin
			@(negedge clk_i);
			check_value("fetch_enable_o", 64'(fetch_enable_o), 64'd0);
		end
		@(posedge clk_i);
		resetn <= 1'b1;

		for (int i = 0; i < soc_mem_pkg::FETCH_DELAY; i++)
		begin
			@(negedge clk_i);
			check_value("fetch_enable_o", 64'(fetch_enable_o), 64'd0);
		end
		repeat (2)
		begin
			@(negedge clk_i);
			check_value("fetch_enable_o", 64'(fetch_enable_o), 64'd1);
		end

		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code > 0 && line.substr(0, 0) != "#")
			begin
				count = $sscanf(line, "%h %h %h %h %h %h", kind, we, addr, wdata, be, exp);
				if (count > 0 && count < 6)
					stop_with_failure($sformatf("malformed stimulus line: %s", line));
				else if (count == 6)
				begin
					lines_run++;
					if (kind == 4'd2)
					begin
						pend_valid = 1'b1;
						pend_addr = addr;
						pend_exp = exp;
					end
					else if (pend_valid)
					begin
						if (kind != 4'd1)
							stop_with_failure("paired instruction line not followed by a data line");
						run_pair(pend_addr, pend_exp, we[0], addr, wdata, be, exp);
						pend_valid = 1'b0;
					end
					else if (kind > 4'd1)
						stop_with_failure($sformatf("unknown access kind in line: %s", line));
					else
						run_access(kind[0], we[0], addr, wdata, be, exp);
				end
			end
		end
		$fclose(fd);

		if (pend_valid)
			stop_with_failure("stimulus file ends inside a paired access");
		if (lines_run == 0)
			stop_with_failure("no stimulus lines were read");
		else
		begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// same-cycle grant, read data one cycle after acceptance
module ext_slave_model
(
	input  logic clk_i,
	input  logic resetn,
	input  soc_mem_pkg::mem_req_t req_i,
	output soc_mem_pkg::mem_rsp_t rsp_o
);

	timeunit 1ns;
	timeprecision 1ps;

	logic rvalid_q;
	soc_mem_pkg::data_t rdata_q;

	always @(posedge clk_i)
	begin
		if (!resetn)
		begin
			rvalid_q <= 1'b0;
			rdata_q <= '0;
		end
		else
		begin
			rvalid_q <= req_i.req;
			// address pattern the stim file expects back
			if (req_i.req)
				rdata_q <= req_i.addr[31:0] ^ 32'ha5a5a5a5;
		end
	end

	always_comb
	begin
		rsp_o.gnt = req_i.req;
		rsp_o.rvalid = resetn && rvalid_q;
		rsp_o.rdata = (resetn && rvalid_q) ? rdata_q : '0;
	end

endmodule
